// File: all.f
+incdir+.
cart_pkg.sv
cart_if.sv
bus_sync.sv
bus_decode.sv
game_rom.sv
sector_loader.sv
cart_top.sv
cart_assertions.sv
cart_checker.sv
tb_cart.sv

// File: bus_decode.sv
`include "cart_consts.svh"

module bus_decode (
    input  logic        sys_clk,
    input  logic        sd_reset,
    console_bus_if.dst  bus,
    rom_access_if.src   rd
);
    import cart_pkg::*;

    localparam cart_addr_t WIN_BASE = `ROM_BASE;

    bus_cycle_t cycle_nxt;
    logic       in_window_nxt;
    rom_addr_t  rom_index_nxt;

    // ======================================================================
    // Window decode and cycle classification
    // ======================================================================
    assign in_window_nxt = (bus.addr >= WIN_BASE);      // $4000 and above
    assign rom_index_nxt = bus.addr - WIN_BASE;         // Wraps below window, unused then

    always_comb begin
        if (!bus.rw) begin
            cycle_nxt = CYC_OTHER;                      // Writes never get data
        end else if (!bus.halt) begin
            cycle_nxt = CYC_DMA_READ;                   // DMA ignores phi2
        end else if (bus.phi2) begin
            cycle_nxt = CYC_CPU_READ;
        end else begin
            cycle_nxt = CYC_IDLE;
        end
    end

    // Second pipeline stage
    always_ff @(posedge sys_clk) begin
        if (sd_reset) begin
            rd.cycle     <= CYC_IDLE;
            rd.in_window <= 1'b0;
            rd.rw        <= 1'b1;
        end else begin
            rd.cycle     <= cycle_nxt;
            rd.in_window <= in_window_nxt;
            rd.rw        <= bus.rw;
        end
    end

    // Index is payload only
    always_ff @(posedge sys_clk) begin
        rd.rom_index <= rom_index_nxt;
    end

endmodule

// File: bus_sync.sv
module bus_sync (
    input  logic                sys_clk,
    input  logic                sd_reset,
    input  cart_pkg::cart_addr_t a,         // Raw console address pins
    input  logic                phi2,
    input  logic                rw,
    input  logic                halt,
    console_bus_if.src          bus
);
    import cart_pkg::*;

    // ======================================================================
    // Single register stage on the console pins
    // ======================================================================
    // Console lines are asynchronous to sys_clk
    // Sampled once, all later logic sees only these flops
    always_ff @(posedge sys_clk) begin
        if (sd_reset) begin
            bus.addr <= '0;
            bus.phi2 <= 1'b0;                   // Idle read
            bus.rw   <= 1'b1;
            bus.halt <= 1'b1;                   // CPU owns bus
        end else begin
            bus.addr <= a;
            bus.phi2 <= phi2;
            bus.rw   <= rw;
            bus.halt <= halt;
        end
    end

endmodule

// File: cart_assertions.sv
module cart_assertions (
    input logic sys_clk,
    input logic sd_reset,
    input logic sd_req,
    input logic sd_ack,
    input logic d_oe,
    input logic buf_oe,     // Active low
    input logic loaded
);

    int violations = 0;     // Read by the testbench top

    // ======================================================================
    // Card handshake
    // ======================================================================
    a_req_held: assert property (@(posedge sys_clk) disable iff (sd_reset)
        (sd_req && !sd_ack) |=> sd_req)
        else begin
            violations++;
            $error("sd_req dropped before sd_ack");
        end

    // ======================================================================
    // Buffer rules
    // ======================================================================
    a_oe_buf: assert property (@(posedge sys_clk) disable iff (sd_reset)
        d_oe |-> !buf_oe)
        else begin
            violations++;
            $error("d_oe high with external buffer disabled");
        end

    a_oe_loaded: assert property (@(posedge sys_clk) disable iff (sd_reset)
        d_oe |-> loaded)
        else begin
            violations++;
            $error("d_oe high before game memory loaded");
        end

endmodule

// File: cart_checker.sv
`include "cart_consts.svh"

module cart_checker #(
    parameter int N_SECTORS = `GAME_SECTORS
) (
    input  logic                             sys_clk,
    input  logic                             sd_reset,
    input  cart_pkg::cart_byte_t             d_out,
    input  logic                             d_oe,
    input  logic                             buf_oe,
    input  logic                             buf_dir,
    input  logic                             sd_req,
    input  logic [`SECTOR_W-1:0]             sd_sector,
    input  logic [$clog2(`SECTOR_BYTES)-1:0] sd_offset,
    input  logic                             led_loading,
    input  logic                             led_loaded,
    input  logic                             chk_en,       // Access on its last cycle
    input  logic                             exp_drive,
    input  cart_pkg::cart_byte_t             exp_data,
    input  logic                             exp_dir,
    input  logic                             exp_loaded,
    input  logic                             test_end,
    input  int                               test_id,
    input  logic                             report_en,
    output int                               error_count
);
    import cart_pkg::*;

    int   total_checks = 0;
    int   total_errors = 0;
    int   test_checks  = 0;
    int   test_errors  = 0;
    int   tests_run    = 0;
    int   hs_count     = 0;                 // Handshakes seen on sd_req
    int   exp_sector   = 0;
    int   exp_offset   = 0;
    logic req_q        = 1'b0;

    assign error_count = total_errors;

    function automatic string test_name(input int id);
        case (id)
            1:       return "reads before loading";
            2:       return "sector loading";
            3:       return "CPU reads";
            4:       return "DMA reads";
            5:       return "no drive";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string name, input int exp_v, input int act_v);
        total_checks++;
        test_checks++;
        if (exp_v != act_v) begin
            total_errors++;
            test_errors++;
            $display("FAIL time=%0t %s expected=0x%0h actual=0x%0h",
                     $time, name, exp_v, act_v);
        end
    endtask

    // ======================================================================
    // Compare on rising edge, outputs hold their last registered value
    // ======================================================================
    always @(posedge sys_clk) begin
        if (sd_reset) begin
            hs_count   = 0;
            exp_sector = 0;
            exp_offset = 0;
        end else if (sd_req && !req_q) begin        // New card request
            check_value("sd_sector", exp_sector, int'(sd_sector));
            check_value("sd_offset", exp_offset, int'(sd_offset));
            hs_count++;
            if (exp_offset == `SECTOR_BYTES - 1) begin
                exp_offset = 0;
                exp_sector++;
            end else begin
                exp_offset++;
            end
        end
        req_q = sd_reset ? 1'b0 : sd_req;

        if (chk_en) begin
            check_value("d_oe", int'(exp_drive), int'(d_oe));
            check_value("buf_oe", int'(!exp_drive), int'(buf_oe));   // Low = on
            check_value("buf_dir", int'(exp_dir), int'(buf_dir));
            check_value("led_loaded", int'(!exp_loaded), int'(led_loaded));
            if (exp_drive) check_value("d_out", int'(exp_data), int'(d_out));
        end

        if (test_end) begin
            if (test_id == 2) begin
                check_value("handshake count", N_SECTORS * `SECTOR_BYTES, hs_count);
                check_value("led_loaded", 0, int'(led_loaded));
                check_value("led_loading", 1, int'(led_loading));
            end
            $display("Test %0d %s: %0d checks, %0d errors",
                     test_id, test_name(test_id), test_checks, test_errors);
            tests_run++;
            test_checks = 0;
            test_errors = 0;
        end

        if (report_en) begin
            $display("Summary: %0d tests, %0d checks, %0d errors",
                     tests_run, total_checks, total_errors);
        end
    end

endmodule

// File: cart_consts.svh
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

// ==========================================================================
// Console bus widths
// ==========================================================================
`define CART_ADDR_W    16           // 6502 address bus
`define CART_DATA_W    8            // Data bus byte

// Cartridge window, $4000 up to the top of the map
`define ROM_BASE       16'h4000

// Game memory depth, 48 KB
`define ROM_BYTES      49152

// ==========================================================================
// Storage card image layout
// ==========================================================================
`define SECTOR_BYTES   512          // Bytes per card sector
`define HEADER_BYTES   128          // Image header at start of sector 0

// Sectors read after reset
// 48 KB game plus header rounds up to 97
`define GAME_SECTORS   97

`define SECTOR_W       7            // Enough for sector 96

`endif

// File: cart_if.sv
// ==========================================================================
// Registered console lines, bus_sync to bus_decode
// ==========================================================================
interface console_bus_if;
    import cart_pkg::*;

    cart_addr_t addr;           // Sampled address
    logic       phi2;
    logic       rw;             // 1 = read
    logic       halt;           // Low during DMA

    modport src (output addr, phi2, rw, halt);
    modport dst (input  addr, phi2, rw, halt);
endinterface

// ==========================================================================
// Decoded access, bus_decode to game_rom
// ==========================================================================
interface rom_access_if;
    import cart_pkg::*;

    bus_cycle_t cycle;          // Classified cycle
    rom_addr_t  rom_index;      // Address minus window base
    logic       rw;             // Delayed copy for buffer direction
    logic       in_window;      // Address inside cartridge window

    modport src (output cycle, rom_index, rw, in_window);
    modport dst (input  cycle, rom_index, rw, in_window);
endinterface

// File: cart_pkg.sv
`include "cart_consts.svh"

package cart_pkg;

    // ======================================================================
    // Data and address types
    // ======================================================================
    typedef logic [`CART_ADDR_W-1:0] cart_addr_t;     // Console address
    typedef logic [`CART_ADDR_W-1:0] rom_addr_t;      // Offset into game memory
    typedef logic [`CART_DATA_W-1:0] cart_byte_t;     // One data byte

    // Kind of console cycle seen on the bus
    typedef enum logic [1:0] {
        CYC_IDLE     = 2'd0,    // Read with phi2 low, CPU not halted
        CYC_CPU_READ = 2'd1,    // phi2 high, halt high
        CYC_DMA_READ = 2'd2,    // Halt low, DMA owns the bus
        CYC_OTHER    = 2'd3     // Any write
    } bus_cycle_t;

    // Sector loader FSM
    typedef enum logic [2:0] {
        LD_WAIT_CARD = 3'd0,    // Card source not ready yet
        LD_REQ       = 3'd1,    // Request up, waiting for ack
        LD_RELEASE   = 3'd2,    // Request down, waiting for ack to drop
        LD_NEXT      = 3'd3,    // Step offset and sector
        LD_DONE      = 3'd4     // Image in memory
    } ld_state_t;

endpackage

// File: cart_top.sv
`include "cart_consts.svh"

module cart_top #(
    parameter int N_SECTORS = `GAME_SECTORS
) (
    input  logic                              sys_clk,
    input  logic                              sd_reset,

    // ======================================================================
    // Console side
    // ======================================================================
    input  logic [`CART_ADDR_W-1:0]           a,
    input  logic                              phi2,
    input  logic                              rw,
    input  logic                              halt,
    output logic [`CART_DATA_W-1:0]           d_out,
    output logic                              d_oe,        // Drive data pins
    output logic                              buf_oe,      // Buffer enable, low = on
    output logic                              buf_dir,

    // ======================================================================
    // Card byte source
    // ======================================================================
    input  logic                              sd_ready,
    input  logic                              sd_ack,
    input  logic [`CART_DATA_W-1:0]           sd_data,
    output logic                              sd_req,
    output logic [`SECTOR_W-1:0]              sd_sector,
    output logic [$clog2(`SECTOR_BYTES)-1:0]  sd_offset,

    output logic                              led_loading,
    output logic                              led_loaded
);
    import cart_pkg::*;

    console_bus_if bus_if ();
    rom_access_if  rd_if ();

    // Loader to memory
    logic       wr_en;
    rom_addr_t  wr_addr;
    cart_byte_t wr_data;
    logic       loaded;

    // Stage 1, pin registers
    bus_sync u_bus_sync (
        .sys_clk  (sys_clk),
        .sd_reset (sd_reset),
        .a        (a),
        .phi2     (phi2),
        .rw       (rw),
        .halt     (halt),
        .bus      (bus_if.src)
    );

    // Stage 2
    bus_decode u_bus_decode (
        .sys_clk  (sys_clk),
        .sd_reset (sd_reset),
        .bus      (bus_if.dst),
        .rd       (rd_if.src)
    );

    // Stage 3, data and buffer controls
    game_rom u_game_rom (
        .sys_clk  (sys_clk),
        .sd_reset (sd_reset),
        .rd       (rd_if.dst),
        .loaded   (loaded),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .d_out    (d_out),
        .d_oe     (d_oe),
        .buf_oe   (buf_oe),
        .buf_dir  (buf_dir)
    );

    sector_loader #(
        .N_SECTORS (N_SECTORS)
    ) u_sector_loader (
        .sys_clk     (sys_clk),
        .sd_reset    (sd_reset),
        .sd_ready    (sd_ready),
        .sd_ack      (sd_ack),
        .sd_data     (sd_data),
        .sd_req      (sd_req),
        .sd_sector   (sd_sector),
        .sd_offset   (sd_offset),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .loaded      (loaded),
        .led_loading (led_loading),
        .led_loaded  (led_loaded)
    );

endmodule

// File: game_rom.sv
`include "cart_consts.svh"

module game_rom (
    input  logic                 sys_clk,
    input  logic                 sd_reset,
    rom_access_if.dst            rd,
    input  logic                 loaded,        // Loader finished
    input  logic                 wr_en,
    input  cart_pkg::rom_addr_t  wr_addr,
    input  cart_pkg::cart_byte_t wr_data,
    output cart_pkg::cart_byte_t d_out,
    output logic                 d_oe,          // Active high, FPGA side
    output logic                 buf_oe,        // Active low, external buffer
    output logic                 buf_dir        // 1 = cart to console
);
    import cart_pkg::*;

    // ======================================================================
    // Game memory
    // ======================================================================
    cart_byte_t mem [0:`ROM_BYTES-1];

    logic read_cycle;
    logic drive;

    // Write side, loader only
    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read side, third stage
    // Index outside the window would run past the array
    always_ff @(posedge sys_clk) begin
        if (rd.in_window) begin
            d_out <= mem[rd.rom_index];
        end
    end

    // ======================================================================
    // Buffer control
    // ======================================================================
    assign read_cycle = (rd.cycle == CYC_CPU_READ) || (rd.cycle == CYC_DMA_READ);
    assign drive      = loaded && rd.in_window && read_cycle;

    // Registered with d_out so data and enable line up
    always_ff @(posedge sys_clk) begin
        if (sd_reset) begin
            d_oe    <= 1'b0;
            buf_oe  <= 1'b1;                    // Buffer off
            buf_dir <= 1'b1;
        end else begin
            d_oe    <= drive;
            buf_oe  <= ~drive;
            buf_dir <= rd.rw;                   // Direction follows rw
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the cartridge testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cart -f all.f -o sim_cart

# Log is searched below
./obj_dir/sim_cart +verilator+error+limit+100 2>&1 | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: sector_loader.sv
`include "cart_consts.svh"

module sector_loader #(
    parameter int N_SECTORS = `GAME_SECTORS     // Sectors to pull from the card
) (
    input  logic                              sys_clk,
    input  logic                              sd_reset,
    input  logic                              sd_ready,     // Card source usable
    input  logic                              sd_ack,
    input  cart_pkg::cart_byte_t              sd_data,
    output logic                              sd_req,
    output logic [`SECTOR_W-1:0]              sd_sector,
    output logic [$clog2(`SECTOR_BYTES)-1:0]  sd_offset,
    output logic                              wr_en,
    output cart_pkg::rom_addr_t               wr_addr,
    output cart_pkg::cart_byte_t              wr_data,
    output logic                              loaded,
    output logic                              led_loading,  // Active low
    output logic                              led_loaded    // Active low
);
    import cart_pkg::*;

    localparam int OFS_W = $clog2(`SECTOR_BYTES);
    localparam int SEC_W = `SECTOR_W;

    localparam logic [SEC_W-1:0] LAST_SECTOR = SEC_W'(N_SECTORS - 1);
    localparam logic [OFS_W-1:0] LAST_OFFSET = OFS_W'(`SECTOR_BYTES - 1);
    localparam logic [OFS_W-1:0] HDR_END     = OFS_W'(`HEADER_BYTES);
    localparam rom_addr_t        ROM_LAST    = rom_addr_t'(`ROM_BYTES - 1);

    ld_state_t state;
    rom_addr_t wr_ptr;              // Next free memory byte
    logic      in_header;
    logic      has_room;
    logic      last_byte;
    logic      last_sector;

    // ======================================================================
    // Position flags
    // ======================================================================
    assign in_header   = (sd_sector == '0) && (sd_offset < HDR_END);  // Image header
    assign has_room    = (wr_ptr <= ROM_LAST);      // Padding past 48 KB dropped
    assign last_byte   = (sd_offset == LAST_OFFSET);
    assign last_sector = (sd_sector == LAST_SECTOR);

    // ======================================================================
    // Loader FSM, one four-phase handshake per byte
    // ======================================================================
    always_ff @(posedge sys_clk) begin
        wr_en <= 1'b0;                              // One-cycle strobe
        if (sd_reset) begin
            state     <= LD_WAIT_CARD;
            sd_req    <= 1'b0;
            sd_sector <= '0;
            sd_offset <= '0;
            wr_ptr    <= '0;
        end else begin
            case (state)
                LD_WAIT_CARD: begin
                    if (sd_ready) begin
                        sd_req <= 1'b1;             // First byte, sector 0 offset 0
                        state  <= LD_REQ;
                    end
                end

                LD_REQ: begin
                    // No timeout, source sets the pace
                    if (sd_ack) begin
                        sd_req  <= 1'b0;
                        wr_data <= sd_data;
                        wr_addr <= wr_ptr;
                        if (!in_header && has_room) begin
                            wr_en  <= 1'b1;
                            wr_ptr <= wr_ptr + 1'b1;
                        end
                        state <= LD_RELEASE;
                    end
                end

                LD_RELEASE: begin
                    if (!sd_ack) state <= LD_NEXT;  // Source finished its half
                end

                LD_NEXT: begin
                    if (last_byte && last_sector) begin
                        state <= LD_DONE;
                    end else begin
                        if (last_byte) begin
                            sd_sector <= sd_sector + 1'b1;
                            sd_offset <= '0;
                        end else begin
                            sd_offset <= sd_offset + 1'b1;
                        end
                        sd_req <= 1'b1;             // New position valid with req
                        state  <= LD_REQ;
                    end
                end

                LD_DONE: begin
                    state <= LD_DONE;               // Stay until next reset
                end

                default: state <= LD_WAIT_CARD;
            endcase
        end
    end

    // Status outputs
    assign loaded      = (state == LD_DONE);
    assign led_loading = loaded;                    // Lit while busy
    assign led_loaded  = ~loaded;                   // Lit once done

endmodule

// File: tb_cart.sv
`include "cart_consts.svh"

module tb_cart;
    import cart_pkg::*;

    localparam int N_SECTORS     = 3;                       // Short image, 1408 game bytes
    localparam int LOADED_BYTES  = N_SECTORS * `SECTOR_BYTES - `HEADER_BYTES;
    localparam int ACCESS_CYCLES = 5;                       // Hold per bus access
    localparam int HS_MAX_CYCLES = 8;                       // Worst case per card byte
    localparam int N_ACCESSES    = 200;
    localparam int LOAD_CYCLES   = N_SECTORS * `SECTOR_BYTES * HS_MAX_CYCLES;
    localparam int BUS_CYCLES    = N_ACCESSES * ACCESS_CYCLES;
    localparam int TIMEOUT_CYCLES = 3 * (LOAD_CYCLES + BUS_CYCLES);   // About 40000
    localparam logic [31:0] RNG_SEED = 32'he0d4ddc1;

    logic        sys_clk;
    logic        sd_reset;
    logic [15:0] a;
    logic        phi2;
    logic        rw;
    logic        halt;
    logic        sd_ready;
    logic        sd_ack;
    cart_byte_t  sd_data;
    cart_byte_t  d_out;
    logic        d_oe;
    logic        buf_oe;
    logic        buf_dir;
    logic        sd_req;
    logic [`SECTOR_W-1:0]             sd_sector;
    logic [$clog2(`SECTOR_BYTES)-1:0] sd_offset;
    logic        led_loading;
    logic        led_loaded;

    // Expected side, read by the checker
    logic        chk_en;
    logic        exp_drive;
    cart_byte_t  exp_data;
    logic        exp_dir;
    logic        exp_loaded;
    logic        test_end;
    logic        report_en;
    int          test_id;
    int          error_count;
    int          cycle_count = 0;
    int          ack_delay;
    int          idx;
    logic [15:0] addr;

    always #50 sys_clk = ~sys_clk;                          // Period 100

    cart_top #(.N_SECTORS(N_SECTORS)) DUT (
        .sys_clk (sys_clk),  .sd_reset (sd_reset),
        .a (a),  .phi2 (phi2),  .rw (rw),  .halt (halt),
        .d_out (d_out),  .d_oe (d_oe),  .buf_oe (buf_oe),  .buf_dir (buf_dir),
        .sd_ready (sd_ready),  .sd_ack (sd_ack),  .sd_data (sd_data),
        .sd_req (sd_req),  .sd_sector (sd_sector),  .sd_offset (sd_offset),
        .led_loading (led_loading),  .led_loaded (led_loaded)
    );

    cart_checker #(.N_SECTORS(N_SECTORS)) u_checker (
        .sys_clk (sys_clk),  .sd_reset (sd_reset),
        .d_out (d_out),  .d_oe (d_oe),  .buf_oe (buf_oe),  .buf_dir (buf_dir),
        .sd_req (sd_req),  .sd_sector (sd_sector),  .sd_offset (sd_offset),
        .led_loading (led_loading),  .led_loaded (led_loaded),
        .chk_en (chk_en),  .exp_drive (exp_drive),  .exp_data (exp_data),
        .exp_dir (exp_dir),  .exp_loaded (exp_loaded),  .test_end (test_end),
        .test_id (test_id),  .report_en (report_en),  .error_count (error_count)
    );

    bind cart_top cart_assertions u_cart_assertions (
        .sys_clk (sys_clk),  .sd_reset (sd_reset),  .sd_req (sd_req),
        .sd_ack (sd_ack),  .d_oe (d_oe),  .buf_oe (buf_oe),  .loaded (loaded)
    );

    // ======================================================================
    // Card image and reference
    // ======================================================================
    // Hash of the card position, every position bit counts
    function automatic cart_byte_t card_byte(input int sector, input int offset);
        logic [31:0] pos;
        logic [31:0] h;
        pos = 32'(sector * `SECTOR_BYTES + offset);
        h   = pos * 32'h9e37;
        return h[15:8] ^ h[7:0] ^ 8'h5a;
    endfunction

    // Game byte i sits after the image header
    function automatic cart_byte_t expected_rom(input int i);
        int pos;
        pos = i + `HEADER_BYTES;
        return card_byte(pos / `SECTOR_BYTES, pos % `SECTOR_BYTES);
    endfunction

    // One bus access, held for ACCESS_CYCLES, checked on the last cycle
    task automatic bus_access(input logic [15:0] adr, input logic p2, input logic rw_v,
                              input logic hlt, input logic drv, input cart_byte_t dat,
                              input logic ld);
        a    = adr;
        phi2 = p2;
        rw   = rw_v;
        halt = hlt;
        repeat (ACCESS_CYCLES - 1) @(negedge sys_clk);
        exp_drive  = drv;
        exp_data   = dat;
        exp_dir    = rw_v;                                  // Buffer direction follows rw
        exp_loaded = ld;
        chk_en     = 1'b1;
        @(negedge sys_clk);
        chk_en = 1'b0;
    endtask

    task automatic close_test();
        test_end = 1'b1;
        @(negedge sys_clk);
        test_end = 1'b0;
    endtask

    // ======================================================================
    // Card byte source, four-phase
    // ======================================================================
    initial begin
        forever begin
            @(negedge sys_clk);
            if (sd_req && !sd_ack) begin
                ack_delay = int'($urandom % 4);             // 0 to 3 cycles
                repeat (ack_delay) @(negedge sys_clk);
                sd_data = card_byte(int'(sd_sector), int'(sd_offset));
                sd_ack  = 1'b1;
                while (sd_req) @(negedge sys_clk);          // Loader takes the byte
                sd_ack = 1'b0;
            end
        end
    end

    // Run limit
    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, loading or bus tests did not finish",
                     cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        void'($urandom(RNG_SEED));
        sys_clk    = 1'b0;
        sd_reset   = 1'b1;
        a          = '0;
        phi2       = 1'b0;
        rw         = 1'b1;
        halt       = 1'b1;
        sd_ready   = 1'b0;                                  // Card held back for test 1
        sd_ack     = 1'b0;
        sd_data    = '0;
        chk_en     = 1'b0;
        exp_drive  = 1'b0;
        exp_data   = '0;
        exp_dir    = 1'b1;
        exp_loaded = 1'b0;
        test_end   = 1'b0;
        report_en  = 1'b0;
        test_id    = 0;
        repeat (10) @(negedge sys_clk);
        sd_reset = 1'b0;
        @(negedge sys_clk);

        test_id = 1;                                        // Reads before loading
        repeat (10) begin
            idx = int'($urandom % LOADED_BYTES);
            bus_access(16'(`ROM_BASE + idx), 1'b1, 1'b1, 1'b1, 1'b0, 8'h00, 1'b0);
        end
        close_test();

        test_id  = 2;                                       // Card load
        sd_ready = 1'b1;
        while (led_loaded) @(negedge sys_clk);
        close_test();

        test_id = 3;                                        // CPU reads
        repeat (60) begin
            idx = int'($urandom % LOADED_BYTES);
            bus_access(16'(`ROM_BASE + idx), 1'b1, 1'b1, 1'b1, 1'b1, expected_rom(idx), 1'b1);
        end
        close_test();

        test_id = 4;                                        // DMA reads, phi2 ignored
        repeat (40) begin
            idx = int'($urandom % LOADED_BYTES);
            bus_access(16'(`ROM_BASE + idx), 1'($urandom & 1), 1'b1, 1'b0, 1'b1,
                       expected_rom(idx), 1'b1);
        end
        close_test();

        test_id = 5;                                        // No drive cases
        repeat (20) begin
            addr = 16'($urandom % `ROM_BASE);               // Below window
            bus_access(addr, 1'b1, 1'b1, 1'b1, 1'b0, 8'h00, 1'b1);
        end
        repeat (20) begin
            addr = 16'(`ROM_BASE + ($urandom % `ROM_BYTES)); // Writes
            bus_access(addr, 1'($urandom & 1), 1'b0, 1'($urandom & 1), 1'b0, 8'h00, 1'b1);
        end
        repeat (20) begin
            addr = 16'(`ROM_BASE + ($urandom % `ROM_BYTES)); // phi2 low, CPU cycle
            bus_access(addr, 1'b0, 1'b1, 1'b1, 1'b0, 8'h00, 1'b1);
        end
        close_test();

        report_en = 1'b1;
        @(negedge sys_clk);
        report_en = 1'b0;
        @(negedge sys_clk);
        if (error_count == 0 && DUT.u_cart_assertions.violations == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("%0d assertion violations seen", DUT.u_cart_assertions.violations);
            $display("Test failed");
        end
        $finish;
    end

endmodule
